//--- build.f
hw/biu_pkg.sv
hw/biu_req_arbiter.sv
hw/biu_axi_channel.sv
hw/biu_resp_router.sv
hw/biu_top.sv
tests/tb_clock_gen.sv
tests/tb_axi_slave_mem.sv
tests/tb_biu.sv

//--- hw/biu_axi_channel.sv
`default_nettype none

module biu_axi_channel (
   input  wire                         aclk,
   input  wire                         arst_n,
   // granted request from the arbiter
   input  wire                         issue,
   input  wire biu_pkg::bus_op_e       issue_op,
   input  wire [biu_pkg::grlen-1:0]    issue_addr,
   input  wire [biu_pkg::grlen-1:0]    issue_wdata,
   input  wire [biu_pkg::strb_w-1:0]   issue_wstrb,
   // status toward arbiter and router
   output logic                        busy,
   output biu_pkg::bus_op_e            pend_op,
   // ar
   output logic [biu_pkg::grlen-1:0]   araddr,
   output logic                        arvalid,
   input  wire                         arready,
   // aw
   output logic [biu_pkg::grlen-1:0]   awaddr,
   output logic                        awvalid,
   input  wire                         awready,
   // w
   output logic [biu_pkg::grlen-1:0]   wdata,
   output logic [biu_pkg::strb_w-1:0]  wstrb,
   output logic                        wlast,
   output logic                        wvalid,
   input  wire                         wready,
   // r or b beat of the outstanding transaction
   input  wire                         resp_done
);

   biu_pkg::chan_state_e state;
   biu_pkg::chan_state_e cur_state;
   biu_pkg::chan_state_e state_nxt;

   // aw and w finish on their own, each remembered until both are in
   logic aw_done;
   logic w_done;
   logic aw_fire;
   logic w_fire;
   logic wr_both;

   // effective state for this cycle
   // the issue cycle is already the address phase, no extra delay
   always_comb begin
      cur_state = state;
      if (state == biu_pkg::st_idle && issue) begin
         if (issue_op == biu_pkg::op_store) begin
            cur_state = biu_pkg::st_addr_wr;
         end else if (issue_op != biu_pkg::op_none) begin
            cur_state = biu_pkg::st_addr_rd;
         end
      end
   end

   // valids held until their own ready
   assign arvalid = (cur_state == biu_pkg::st_addr_rd);
   assign awvalid = (cur_state == biu_pkg::st_addr_wr) & ~aw_done;
   assign wvalid  = (cur_state == biu_pkg::st_addr_wr) & ~w_done;
   // single beat, every w is the last
   assign wlast   = wvalid;

   assign aw_fire = awvalid & awready;
   assign w_fire  = wvalid & wready;
   assign wr_both = (aw_done | aw_fire) & (w_done | w_fire);

   // arbiter regs are frozen while busy
   // so address and data stay stable under back-pressure
   assign araddr = issue_addr;
   assign awaddr = issue_addr;
   assign wdata  = issue_wdata;
   assign wstrb  = issue_wstrb;

   always_comb begin
      state_nxt = cur_state;
      case (cur_state)
         biu_pkg::st_addr_rd: begin
            if (arready) begin
               state_nxt = biu_pkg::st_wait_r;
            end
         end
         biu_pkg::st_wait_r: begin
            if (resp_done) begin
               state_nxt = biu_pkg::st_idle;
            end
         end
         biu_pkg::st_addr_wr: begin
            if (wr_both) begin
               state_nxt = biu_pkg::st_wait_b;
            end
         end
         biu_pkg::st_wait_b: begin
            if (resp_done) begin
               state_nxt = biu_pkg::st_idle;
            end
         end
         default: begin
            state_nxt = biu_pkg::st_idle;
         end
      endcase
   end

   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= biu_pkg::st_idle;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
         pend_op <= biu_pkg::op_none;
      end else begin
         state <= state_nxt;
         // done flags live only inside the write address phase
         if (cur_state == biu_pkg::st_addr_wr && !wr_both) begin
            aw_done <= aw_done | aw_fire;
            w_done  <= w_done | w_fire;
         end else begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
         end
         // operation awaiting its response
         if (issue) begin
            pend_op <= issue_op;
         end else if (resp_done) begin
            pend_op <= biu_pkg::op_none;
         end
      end
   end

   // issue cycle counts as busy before the state moves
   assign busy = (state != biu_pkg::st_idle) | issue;

endmodule

`default_nettype wire

//--- hw/biu_pkg.sv
`default_nettype none

package biu_pkg;

   // core register width, also the AXI data and address width
   localparam int grlen = 32;

   // one strobe bit per byte lane
   localparam int strb_w = grlen / 8;

   // AXI response field
   localparam int resp_w = 2;

   // exception code field toward the core
   localparam int exccode_w = 6;

   // bus error on an instruction fetch
   localparam logic [exccode_w-1:0] exc_fetch_bus = 6'h06;

   // bus error on a load or a store
   localparam logic [exccode_w-1:0] exc_data_bus = 6'h07;

   // anything other than OKAY is treated as an error
   localparam logic [resp_w-1:0] axi_resp_okay = 2'b00;

   // operation granted by the arbiter and tracked until its response
   typedef enum logic [1:0] {
      op_none  = 2'd0,
      op_fetch = 2'd1,
      op_load  = 2'd2,
      op_store = 2'd3
   } bus_op_e;

   // channel controller states
   // read path  idle -> addr_rd -> wait_r -> idle
   // write path idle -> addr_wr -> wait_b -> idle
   typedef enum logic [2:0] {
      st_idle    = 3'd0,
      st_addr_rd = 3'd1,
      st_wait_r  = 3'd2,
      st_addr_wr = 3'd3,
      st_wait_b  = 3'd4
   } chan_state_e;

endpackage

`default_nettype wire

//--- hw/biu_req_arbiter.sv
`default_nettype none

module biu_req_arbiter (
   input  wire                         aclk,
   input  wire                         arst_n,
   // fetch side
   input  wire                         inst_req,
   input  wire [biu_pkg::grlen-1:0]    inst_addr,
   output logic                        inst_addr_ok,
   // load/store side
   input  wire                         data_req,
   input  wire                         data_wr,
   input  wire [biu_pkg::strb_w-1:0]   data_wstrb,
   input  wire [biu_pkg::grlen-1:0]    data_addr,
   input  wire [biu_pkg::grlen-1:0]    data_wdata,
   output logic                        data_addr_ok,
   // channel controller still owns the bus
   input  wire                         busy,
   // granted request, one cycle after acceptance
   output logic                        issue,
   output biu_pkg::bus_op_e            issue_op,
   output logic [biu_pkg::grlen-1:0]   issue_addr,
   output logic [biu_pkg::grlen-1:0]   issue_wdata,
   output logic [biu_pkg::strb_w-1:0]  issue_wstrb
);

   logic             accept_ok;
   logic             grant;
   biu_pkg::bus_op_e grant_op;

   // bus free and no grant in flight
   // the issue cycle is masked too so a held req is not taken twice
   assign accept_ok = ~busy & ~issue;

   // data side first, fetch only when no data request at all
   assign data_addr_ok = data_req & accept_ok;
   assign inst_addr_ok = inst_req & ~data_req & accept_ok;

   assign grant = data_addr_ok | inst_addr_ok;

   // store over load, load over fetch
   always_comb begin
      if (data_addr_ok) begin
         if (data_wr) begin
            grant_op = biu_pkg::op_store;
         end else begin
            grant_op = biu_pkg::op_load;
         end
      end else if (inst_addr_ok) begin
         grant_op = biu_pkg::op_fetch;
      end else begin
         grant_op = biu_pkg::op_none;
      end
   end

   // issue strobe and the granted operation
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         issue    <= 1'b0;
         issue_op <= biu_pkg::op_none;
      end else begin
         issue <= grant;
         if (grant) begin
            issue_op <= grant_op;
         end
      end
   end

   // address and write payload
   // stays put until the next grant, which cannot come while busy
   always_ff @(posedge aclk) begin
      if (data_addr_ok) begin
         issue_addr  <= data_addr;
         issue_wdata <= data_wdata;
         issue_wstrb <= data_wstrb;
      end else if (inst_addr_ok) begin
         issue_addr  <= inst_addr;
         // fetch never writes
         issue_wstrb <= '0;
      end
   end

endmodule

`default_nettype wire

//--- hw/biu_resp_router.sv
`default_nettype none

module biu_resp_router (
   input  wire                            aclk,
   input  wire                            arst_n,
   // operation awaiting its response
   input  wire biu_pkg::bus_op_e          pend_op,
   // r
   input  wire [biu_pkg::grlen-1:0]       rdata,
   input  wire [biu_pkg::resp_w-1:0]      rresp,
   input  wire                            rvalid,
   output logic                           rready,
   // b
   input  wire [biu_pkg::resp_w-1:0]      bresp,
   input  wire                            bvalid,
   output logic                           bready,
   // fetch result thrown away by the core
   input  wire                            inst_cancel,
   output logic                           resp_done,
   // fetch side
   output logic [biu_pkg::grlen-1:0]      inst_rdata,
   output logic                           inst_valid,
   output logic                           inst_exception,
   output logic [biu_pkg::exccode_w-1:0]  inst_exccode,
   // load/store side
   output logic [biu_pkg::grlen-1:0]      data_rdata,
   output logic                           data_data_ok,
   output logic                           data_exception,
   output logic [biu_pkg::exccode_w-1:0]  data_exccode
);

   logic fetch_pend;
   logic load_pend;
   logic store_pend;
   logic r_fire;
   logic b_fire;
   logic r_err;
   logic b_err;
   logic fetch_beat;
   logic load_beat;
   logic store_beat;
   logic cancel_q;
   logic inst_drop;

   // one beat at a time, never stall the slave
   assign rready = 1'b1;
   assign bready = 1'b1;

   assign fetch_pend = (pend_op == biu_pkg::op_fetch);
   assign load_pend  = (pend_op == biu_pkg::op_load);
   assign store_pend = (pend_op == biu_pkg::op_store);

   assign r_fire = rvalid & rready;
   assign b_fire = bvalid & bready;
   assign r_err  = (rresp != biu_pkg::axi_resp_okay);
   assign b_err  = (bresp != biu_pkg::axi_resp_okay);

   // beats that belong to the outstanding transaction
   assign fetch_beat = r_fire & fetch_pend;
   assign load_beat  = r_fire & load_pend;
   assign store_beat = b_fire & store_pend;

   assign resp_done = fetch_beat | load_beat | store_beat;

   // cancel seen while the fetch is in flight
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         cancel_q <= 1'b0;
      end else if (resp_done) begin
         cancel_q <= 1'b0;
      end else if (inst_cancel && fetch_pend) begin
         cancel_q <= 1'b1;
      end
   end

   // a cancel in the beat cycle itself also drops the result
   assign inst_drop = cancel_q | inst_cancel;

   // fetch side, data masked when the beat is not ours
   assign inst_rdata     = rdata & {biu_pkg::grlen{fetch_pend}};
   assign inst_valid     = fetch_beat & ~inst_drop;
   assign inst_exception = fetch_beat & r_err & ~inst_drop;
   assign inst_exccode   = inst_exception ? biu_pkg::exc_fetch_bus : '0;

   // load data from r, store completion from b
   assign data_rdata     = rdata & {biu_pkg::grlen{load_pend}};
   assign data_data_ok   = load_beat | store_beat;
   assign data_exception = (load_beat & r_err) | (store_beat & b_err);
   assign data_exccode   = data_exception ? biu_pkg::exc_data_bus : '0;

endmodule

`default_nettype wire

//--- hw/biu_top.sv
`default_nettype none

module biu_top (
   input  wire                            aclk,
   input  wire                            arst_n,
   // core fetch side
   input  wire                            inst_req,
   input  wire [biu_pkg::grlen-1:0]       inst_addr,
   input  wire                            inst_cancel,
   output wire                            inst_addr_ok,
   output wire [biu_pkg::grlen-1:0]       inst_rdata,
   output wire                            inst_valid,
   output wire                            inst_exception,
   output wire [biu_pkg::exccode_w-1:0]   inst_exccode,
   // core load/store side
   input  wire                            data_req,
   input  wire                            data_wr,
   input  wire [biu_pkg::strb_w-1:0]      data_wstrb,
   input  wire [biu_pkg::grlen-1:0]       data_addr,
   input  wire [biu_pkg::grlen-1:0]       data_wdata,
   output wire                            data_addr_ok,
   output wire [biu_pkg::grlen-1:0]       data_rdata,
   output wire                            data_data_ok,
   output wire                            data_exception,
   output wire [biu_pkg::exccode_w-1:0]   data_exccode,
   // ar
   output wire [biu_pkg::grlen-1:0]       araddr,
   output wire                            arvalid,
   input  wire                            arready,
   // r
   input  wire [biu_pkg::grlen-1:0]       rdata,
   input  wire [biu_pkg::resp_w-1:0]      rresp,
   input  wire                            rvalid,
   output wire                            rready,
   // aw
   output wire [biu_pkg::grlen-1:0]       awaddr,
   output wire                            awvalid,
   input  wire                            awready,
   // w
   output wire [biu_pkg::grlen-1:0]       wdata,
   output wire [biu_pkg::strb_w-1:0]      wstrb,
   output wire                            wlast,
   output wire                            wvalid,
   input  wire                            wready,
   // b
   input  wire [biu_pkg::resp_w-1:0]      bresp,
   input  wire                            bvalid,
   output wire                            bready
);

   // arbiter to channel controller
   logic                        issue;
   biu_pkg::bus_op_e            issue_op;
   logic [biu_pkg::grlen-1:0]   issue_addr;
   logic [biu_pkg::grlen-1:0]   issue_wdata;
   logic [biu_pkg::strb_w-1:0]  issue_wstrb;
   // channel controller back to arbiter and on to router
   logic                        busy;
   biu_pkg::bus_op_e            pend_op;
   // router back to channel controller
   logic                        resp_done;

   // decode, pick one request
   biu_req_arbiter u_req_arbiter (
      .aclk         (aclk),
      .arst_n       (arst_n),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .inst_addr_ok (inst_addr_ok),
      .data_req     (data_req),
      .data_wr      (data_wr),
      .data_wstrb   (data_wstrb),
      .data_addr    (data_addr),
      .data_wdata   (data_wdata),
      .data_addr_ok (data_addr_ok),
      .busy         (busy),
      .issue        (issue),
      .issue_op     (issue_op),
      .issue_addr   (issue_addr),
      .issue_wdata  (issue_wdata),
      .issue_wstrb  (issue_wstrb)
   );

   // execute, run the AXI address and write channels
   biu_axi_channel u_axi_channel (
      .aclk        (aclk),
      .arst_n      (arst_n),
      .issue       (issue),
      .issue_op    (issue_op),
      .issue_addr  (issue_addr),
      .issue_wdata (issue_wdata),
      .issue_wstrb (issue_wstrb),
      .busy        (busy),
      .pend_op     (pend_op),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wlast       (wlast),
      .wvalid      (wvalid),
      .wready      (wready),
      .resp_done   (resp_done)
   );

   // result, route r and b back to the core
   biu_resp_router u_resp_router (
      .aclk           (aclk),
      .arst_n         (arst_n),
      .pend_op        (pend_op),
      .rdata          (rdata),
      .rresp          (rresp),
      .rvalid         (rvalid),
      .rready         (rready),
      .bresp          (bresp),
      .bvalid         (bvalid),
      .bready         (bready),
      .inst_cancel    (inst_cancel),
      .resp_done      (resp_done),
      .inst_rdata     (inst_rdata),
      .inst_valid     (inst_valid),
      .inst_exception (inst_exception),
      .inst_exccode   (inst_exccode),
      .data_rdata     (data_rdata),
      .data_data_ok   (data_data_ok),
      .data_exception (data_exception),
      .data_exccode   (data_exccode)
   );

endmodule

`default_nettype wire

//--- tests/tb_axi_slave_mem.sv
`default_nettype none

module tb_axi_slave_mem (
   input  wire         aclk,
   input  wire         arst_n,
   input  wire [31:0]  araddr,
   input  wire         arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  wire         rready,
   input  wire [31:0]  awaddr,
   input  wire         awvalid,
   output logic        awready,
   input  wire [31:0]  wdata,
   input  wire [3:0]   wstrb,
   input  wire         wlast,
   input  wire         wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  wire         bready
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] mem [256];
   logic [31:0] lfsr;
   logic [31:0] raddr;
   logic [31:0] waddr;
   logic [31:0] wd;
   logic [3:0]  ws;
   logic [1:0]  rd_dly;
   logic [1:0]  wr_dly;
   logic [1:0]  aw_dly;
   logic [1:0]  w_dly;
   logic        aw_got;
   logic        w_got;
   int          cnt;

   // galois lfsr, one step per bit
   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   // 0 to 3 cycles
   function automatic logic [1:0] rand_delay();
      logic [1:0] d;
      d[0] = next_bit();
      d[1] = next_bit();
      return d;
   endfunction

   // every byte depends on the full word index
   function automatic logic [31:0] fill_word(input logic [7:0] i);
      return {i ^ 8'ha5, i, ~i, i + 8'h3c};
   endfunction

   initial begin
      lfsr    = 32'd45;
      arready = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      rresp   = 2'b00;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      bresp   = 2'b00;
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(i[7:0]);
      end
   end

   // read path, AR then one R beat
   always begin
      @(negedge aclk);
      if (arst_n && arvalid) begin
         rd_dly = rand_delay();
         repeat (rd_dly) @(negedge aclk);
         arready = 1'b1;
         @(posedge aclk);
         raddr = araddr;
         @(negedge aclk);
         arready = 1'b0;
         rd_dly = rand_delay();
         repeat (rd_dly) @(negedge aclk);
         // bit 31 is the error region
         rresp  = raddr[31] ? 2'b10 : 2'b00;
         rdata  = raddr[31] ? 32'h0 : mem[raddr[9:2]];
         rvalid = 1'b1;
         @(negedge aclk);
         rvalid = 1'b0;
      end
   end

   // write path, AW and W accepted independently, then one B beat
   always begin
      @(negedge aclk);
      if (arst_n && (awvalid || wvalid)) begin
         aw_dly = rand_delay();
         w_dly  = rand_delay();
         aw_got = 1'b0;
         w_got  = 1'b0;
         cnt    = 0;
         while (!(aw_got && w_got)) begin
            awready = !aw_got && (cnt >= aw_dly);
            wready  = !w_got && (cnt >= w_dly);
            @(posedge aclk);
            if (awvalid && awready) begin
               aw_got = 1'b1;
               waddr  = awaddr;
            end
            if (wvalid && wready) begin
               w_got = 1'b1;
               wd    = wdata;
               ws    = wstrb;
            end
            cnt++;
            @(negedge aclk);
         end
         awready = 1'b0;
         wready  = 1'b0;
         wr_dly = rand_delay();
         repeat (wr_dly) @(negedge aclk);
         // only strobed lanes, nothing in the error region
         if (!waddr[31]) begin
            for (int b = 0; b < 4; b++) begin
               if (ws[b]) begin
                  mem[waddr[9:2]][8*b +: 8] = wd[8*b +: 8];
               end
            end
         end
         bresp  = waddr[31] ? 2'b10 : 2'b00;
         bvalid = 1'b1;
         @(negedge aclk);
         bvalid = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_biu.sv
`default_nettype none

module tb_biu;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int wait_limit = 60;

   logic        aclk;
   logic        arst_n;
   logic        inst_req;
   logic [31:0] inst_addr;
   logic        inst_cancel;
   wire         inst_addr_ok;
   wire  [31:0] inst_rdata;
   wire         inst_valid;
   wire         inst_exception;
   wire  [5:0]  inst_exccode;
   logic        data_req;
   logic        data_wr;
   logic [3:0]  data_wstrb;
   logic [31:0] data_addr;
   logic [31:0] data_wdata;
   wire         data_addr_ok;
   wire  [31:0] data_rdata;
   wire         data_data_ok;
   wire         data_exception;
   wire  [5:0]  data_exccode;
   wire  [31:0] araddr;
   wire         arvalid;
   wire         arready;
   wire  [31:0] rdata;
   wire  [1:0]  rresp;
   wire         rvalid;
   wire         rready;
   wire  [31:0] awaddr;
   wire         awvalid;
   wire         awready;
   wire  [31:0] wdata;
   wire  [3:0]  wstrb;
   wire         wlast;
   wire         wvalid;
   wire         wready;
   wire  [1:0]  bresp;
   wire         bvalid;
   wire         bready;

   logic [31:0] shadow [256];
   logic [31:0] lfsr;
   // previous-cycle view of the AXI address and write channels
   logic        prev_arvalid;
   logic        prev_arready;
   logic [31:0] prev_araddr;
   logic        prev_awvalid;
   logic        prev_awready;
   logic [31:0] prev_awaddr;
   logic        prev_wvalid;
   logic        prev_wready;
   logic [31:0] prev_wdata;
   logic [3:0]  prev_wstrb;
   int          aw_count;
   int          w_count;
   int          ok_count;
   logic [31:0] got_data;
   logic        got_exc;
   logic [5:0]  got_code;

   tb_clock_gen u_clock_gen (
      .aclk   (aclk),
      .arst_n (arst_n)
   );

   biu_top u_biu_top (.*);

   tb_axi_slave_mem u_slave_mem (.*);

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("** Error: %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_problem(input string what);
      $display("** Error: %s", what);
      $display("Test FAILED");
      $fatal(1);
   endtask

   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = next_bit();
      end
      return v;
   endfunction

   // same fill as the slave memory at power up
   function automatic logic [31:0] fill_word(input logic [7:0] i);
      return {i ^ 8'ha5, i, ~i, i + 8'h3c};
   endfunction

   // channel monitors sample before the edge updates anything
   always @(posedge aclk) begin
      if (arst_n) begin
         // held valids keep address and payload under back-pressure
         if (prev_arvalid && !prev_arready) begin
            assert (arvalid) else report_problem("arvalid dropped before arready");
            assert (araddr == prev_araddr)
               else report_mismatch("ar_stable", prev_araddr, araddr);
         end
         if (prev_awvalid && !prev_awready) begin
            assert (awvalid) else report_problem("awvalid dropped before awready");
            assert (awaddr == prev_awaddr)
               else report_mismatch("aw_stable", prev_awaddr, awaddr);
         end
         if (prev_wvalid && !prev_wready) begin
            assert (wvalid) else report_problem("wvalid dropped before wready");
            assert (wdata == prev_wdata)
               else report_mismatch("w_stable", prev_wdata, wdata);
            assert (wstrb == prev_wstrb)
               else report_mismatch("wstrb_stable", prev_wstrb, wstrb);
         end
         if (wvalid) begin
            assert (wlast) else report_mismatch("wlast", 1, wlast);
         end
         assert (rready && bready) else report_problem("rready or bready low");
         if (awvalid && awready) aw_count++;
         if (wvalid && wready) w_count++;
         if (data_data_ok) ok_count++;
      end
      prev_arvalid = arvalid;
      prev_arready = arready;
      prev_araddr  = araddr;
      prev_awvalid = awvalid;
      prev_awready = awready;
      prev_awaddr  = awaddr;
      prev_wvalid  = wvalid;
      prev_wready  = wready;
      prev_wdata   = wdata;
      prev_wstrb   = wstrb;
   end

   task automatic wait_data_addr_ok();
      int n;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for data_addr_ok");
      end while (!data_addr_ok);
   endtask

   task automatic wait_inst_addr_ok();
      int n;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for inst_addr_ok");
      end while (!inst_addr_ok);
   endtask

   // result captured in the beat cycle itself
   task automatic wait_data_ok();
      int n;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for data_data_ok");
      end while (!data_data_ok);
      got_data = data_rdata;
      got_exc  = data_exception;
      got_code = data_exccode;
   endtask

   task automatic wait_inst_valid();
      int n;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for inst_valid");
      end while (!inst_valid);
      got_data = inst_rdata;
      got_exc  = inst_exception;
      got_code = inst_exccode;
   endtask

   // one load or store and its handshake counts
   // core inputs are scrambled after acceptance so the bus must use its own copy
   task automatic data_access(input logic wr, input logic [3:0] strb,
                              input logic [31:0] addr, input logic [31:0] wd);
      int ok0;
      int aw0;
      int w0;
      @(negedge aclk);
      data_req   = 1'b1;
      data_wr    = wr;
      data_wstrb = strb;
      data_addr  = addr;
      data_wdata = wd;
      wait_data_addr_ok();
      ok0 = ok_count;
      aw0 = aw_count;
      w0  = w_count;
      @(negedge aclk);
      data_req   = 1'b0;
      data_wstrb = ~strb;
      data_addr  = ~addr;
      data_wdata = ~wd;
      wait_data_ok();
      repeat (4) @(posedge aclk);
      assert (ok_count - ok0 == 1) else report_mismatch("data_ok_count", 1, ok_count - ok0);
      if (wr) begin
         assert (aw_count - aw0 == 1) else report_mismatch("aw_count", 1, aw_count - aw0);
         assert (w_count - w0 == 1) else report_mismatch("w_count", 1, w_count - w0);
         if (!addr[31]) begin
            for (int b = 0; b < 4; b++) begin
               if (strb[b]) shadow[addr[9:2]][8*b +: 8] = wd[8*b +: 8];
            end
         end
      end
   endtask

   task automatic fetch(input logic [31:0] addr);
      @(negedge aclk);
      inst_req  = 1'b1;
      inst_addr = addr;
      wait_inst_addr_ok();
      @(negedge aclk);
      inst_req  = 1'b0;
      inst_addr = ~addr;
      wait_inst_valid();
   endtask

   task automatic check_fetch(input logic [31:0] addr);
      fetch(addr);
      assert (got_data == shadow[addr[9:2]])
         else report_mismatch("fetch_data", shadow[addr[9:2]], got_data);
      assert (!got_exc) else report_mismatch("fetch_exception", 0, got_exc);
   endtask

   // cancel spans the issue cycle and the first pending cycle
   // every cycle up to the R beat is watched
   task automatic cancelled_fetch(input logic [31:0] addr);
      int   n;
      logic beat;
      @(negedge aclk);
      inst_req  = 1'b1;
      inst_addr = addr;
      wait_inst_addr_ok();
      @(negedge aclk);
      inst_req    = 1'b0;
      inst_addr   = ~addr;
      inst_cancel = 1'b1;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for the cancelled R beat");
         assert (!inst_valid && !inst_exception)
            else report_problem("cancelled fetch still returned a result");
         beat = rvalid;
         @(negedge aclk);
         if (n == 2) inst_cancel = 1'b0;
      end while (!beat);
      inst_cancel = 1'b0;
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      int          n;
      lfsr        = 32'd45;
      inst_req    = 1'b0;
      inst_addr   = '0;
      inst_cancel = 1'b0;
      data_req    = 1'b0;
      data_wr     = 1'b0;
      data_wstrb  = '0;
      data_addr   = '0;
      data_wdata  = '0;
      aw_count    = 0;
      w_count     = 0;
      ok_count    = 0;
      for (int i = 0; i < 256; i++) begin
         shadow[i] = fill_word(i[7:0]);
      end
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("reset never released");
      end while (!arst_n);

      // plain fetches
      check_fetch(32'h0000_0010);
      check_fetch(32'h0000_0044);
      check_fetch(rand_bits(8) << 2);

      // store with random strobe then load back
      for (int k = 0; k < 6; k++) begin
         a = rand_bits(8) << 2;
         d = rand_bits(32);
         s = 4'(rand_bits(4));
         data_access(1'b1, s, a, d);
         assert (!got_exc) else report_mismatch("store_exception", 0, got_exc);
         data_access(1'b0, 4'h0, a, 32'h0);
         assert (got_data == shadow[a[9:2]])
            else report_mismatch("store_load", shadow[a[9:2]], got_data);
         assert (!got_exc) else report_mismatch("load_exception", 0, got_exc);
      end

      // data wins when raised together with a fetch
      @(negedge aclk);
      data_req   = 1'b1;
      data_wr    = 1'b0;
      data_addr  = 32'h0000_0080;
      inst_req   = 1'b1;
      inst_addr  = 32'h0000_0020;
      @(posedge aclk);
      assert (data_addr_ok) else report_mismatch("prio_data_addr_ok", 1, data_addr_ok);
      assert (!inst_addr_ok) else report_mismatch("prio_inst_addr_ok", 0, inst_addr_ok);
      @(negedge aclk);
      data_req = 1'b0;
      n = 0;
      do begin
         @(posedge aclk);
         n++;
         if (n > wait_limit) report_problem("timeout waiting for the priority load");
         assert (!inst_addr_ok) else report_problem("fetch accepted before the load ended");
      end while (!data_data_ok);
      assert (data_rdata == shadow[32])
         else report_mismatch("prio_load", shadow[32], data_rdata);
      // held fetch goes in the cycle right after the load response
      @(posedge aclk);
      assert (inst_addr_ok) else report_mismatch("prio_fetch_accept", 1, inst_addr_ok);
      @(negedge aclk);
      inst_req = 1'b0;
      wait_inst_valid();
      assert (got_data == shadow[8]) else report_mismatch("prio_fetch", shadow[8], got_data);

      // cancelled fetch followed by a normal one
      cancelled_fetch(32'h0000_0030);
      check_fetch(32'h0000_0034);

      // error region
      data_access(1'b0, 4'h0, 32'h8000_0040, 32'h0);
      assert (got_exc) else report_mismatch("err_load_exc", 1, got_exc);
      assert (got_code == biu_pkg::exc_data_bus)
         else report_mismatch("err_load_code", biu_pkg::exc_data_bus, got_code);
      data_access(1'b1, 4'hf, 32'h8000_0044, 32'hdead_beef);
      assert (got_exc) else report_mismatch("err_store_exc", 1, got_exc);
      assert (got_code == biu_pkg::exc_data_bus)
         else report_mismatch("err_store_code", biu_pkg::exc_data_bus, got_code);
      fetch(32'h8000_0048);
      assert (got_exc) else report_mismatch("err_fetch_exc", 1, got_exc);
      assert (got_code == biu_pkg::exc_fetch_bus)
         else report_mismatch("err_fetch_code", biu_pkg::exc_fetch_bus, got_code);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic aclk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // 4 ns period
   initial begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   // reset held low for two rising edges, released on a falling edge
   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge aclk);
      @(negedge aclk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire
